// ==== delay_bank.sv ====
// delay register bank: pending values loaded one at a time, committed together to active
`timescale 1ns/1ps
`include "phy_consts.svh"

module delay_bank #(
    parameter int NUM_ENTRIES = `LANE_DLY_NUM
) (
    input  logic    rst_in,             // clock
    input  logic    rst_i,              // synced reset
    dly_wr_if.bank  wr_bus
);
    import phy_pkg::*;

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    dly_val_t   pending_q [NUM_ENTRIES];    // loaded, not yet applied
    dly_val_t   active_q  [NUM_ENTRIES];    // would feed the io delay cells
    logic [IDX_W-1:0] wr_sel;
    logic [IDX_W-1:0] rd_sel;
    logic       wr_ok;
    logic       rd_ok;

    assign wr_ok  = (wr_bus.wr_idx < NUM_ENTRIES);  // drop loads past the end
    assign rd_ok  = (wr_bus.rd_idx < NUM_ENTRIES);
    assign wr_sel = wr_bus.wr_idx[IDX_W-1:0];
    assign rd_sel = wr_bus.rd_idx[IDX_W-1:0];

    always_ff @(posedge rst_in or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                pending_q[i] <= '0;
                active_q[i]  <= '0;
            end
        end else begin
            if (wr_bus.wr_en && wr_ok) begin
                pending_q[wr_sel] <= wr_bus.wr_data;
            end
            if (wr_bus.commit) begin
                active_q <= pending_q;          // whole bank at once
            end
        end
    end

    assign wr_bus.rd_data = rd_ok ? active_q[rd_sel] : '0;

    // load and set together: active gets the value pending before the load
    a_commit_order: assert property (@(posedge rst_in) disable iff (rst_i)
        (wr_bus.commit && wr_bus.wr_en && wr_ok)
        |=> (active_q[$past(wr_sel)] == $past(pending_q[wr_sel])));

endmodule

// ==== dly_cfg_ctrl.sv ====
// delay config controller with reset sync, write decode to banks or phase shifter and readback mux
`timescale 1ns/1ps
`include "phy_consts.svh"

module dly_cfg_ctrl (
    input  logic                   rst_in,      // clock
    input  logic                   clk_div,     // async active-high reset
    input  logic [`DLY_ADDR_W-1:0] dly_addr_i,
    input  phy_pkg::dly_val_t      dly_data_i,
    input  logic                   ld_delay_i,
    input  logic                   set_i,
    input  logic [`DLY_ADDR_W-1:0] mon_addr_i,
    dly_wr_if.ctrl                 lane0_o,
    dly_wr_if.ctrl                 lane1_o,
    dly_wr_if.ctrl                 cmda_o,
    output logic                   ps_we_o,
    output phy_pkg::phase_t        ps_target_o,
    output phy_pkg::dly_val_t      mon_data_o,
    output logic                   rst_sync_o
);
    import phy_pkg::*;

    logic [1:0]             rst_pipe;           // falling-edge sync chain
    logic                   rst_sync;
    dly_target_e            wr_tgt;             // target of incoming load
    dly_target_e            mon_tgt;            // target of readback address
    logic                   ld_lane0_q;
    logic                   ld_lane1_q;
    logic                   ld_cmda_q;
    logic                   commit_q;
    logic [`BANK_IDX_W-1:0] wr_idx_q;           // shared by all banks
    dly_val_t               wr_data_q;          // also carries the phase target
    dly_val_t               mon_nxt;

    // upper bits pick the bank and the top block holds the shifter at one address
    function automatic dly_target_e decode_tgt(input logic [`DLY_ADDR_W-1:0] addr);
        dly_target_e tgt;
        case (addr[`BANK_SEL_MSB:`BANK_SEL_LSB])
            2'd0:    tgt = TGT_LANE0;
            2'd1:    tgt = TGT_LANE1;
            2'd2:    tgt = TGT_CMDA;
            default: tgt = (addr == `PS_ADDR) ? TGT_PHASE : TGT_NONE;
        endcase
        return tgt;
    endfunction

    // release lands two falling edges after clk_div drops
    always_ff @(negedge rst_in or posedge clk_div) begin
        if (clk_div) begin
            rst_pipe <= 2'b11;
        end else begin
            rst_pipe <= {rst_pipe[0], 1'b0};
        end
    end
    assign rst_sync   = rst_pipe[1];
    assign rst_sync_o = rst_sync;

    assign wr_tgt  = decode_tgt(dly_addr_i);
    assign mon_tgt = decode_tgt(mon_addr_i);

    always_ff @(posedge rst_in or posedge rst_sync) begin
        if (rst_sync) begin
            ld_lane0_q <= 1'b0;
            ld_lane1_q <= 1'b0;
            ld_cmda_q  <= 1'b0;
            ps_we_o    <= 1'b0;
            commit_q   <= 1'b0;
            mon_data_o <= '0;
        end else begin
            ld_lane0_q <= ld_delay_i && (wr_tgt == TGT_LANE0);
            ld_lane1_q <= ld_delay_i && (wr_tgt == TGT_LANE1);
            ld_cmda_q  <= ld_delay_i && (wr_tgt == TGT_CMDA);
            ps_we_o    <= ld_delay_i && (wr_tgt == TGT_PHASE);
            commit_q   <= set_i;                // same stage as loads so set sees old pending
            mon_data_o <= mon_nxt;
        end
    end

    // payload captured with the load strobe
    always_ff @(posedge rst_in) begin
        if (ld_delay_i) begin
            wr_idx_q  <= dly_addr_i[`BANK_IDX_W-1:0];
            wr_data_q <= dly_data_i;
        end
    end

    always_comb begin
        case (mon_tgt)
            TGT_LANE0: mon_nxt = lane0_o.rd_data;
            TGT_LANE1: mon_nxt = lane1_o.rd_data;
            TGT_CMDA:  mon_nxt = cmda_o.rd_data;
            default:   mon_nxt = '0;            // phase reg and holes read 0
        endcase
    end

    assign lane0_o.wr_idx  = wr_idx_q;
    assign lane0_o.wr_data = wr_data_q;
    assign lane0_o.wr_en   = ld_lane0_q;
    assign lane0_o.commit  = commit_q;
    assign lane0_o.rd_idx  = mon_addr_i[`BANK_IDX_W-1:0];

    assign lane1_o.wr_idx  = wr_idx_q;
    assign lane1_o.wr_data = wr_data_q;
    assign lane1_o.wr_en   = ld_lane1_q;
    assign lane1_o.commit  = commit_q;
    assign lane1_o.rd_idx  = mon_addr_i[`BANK_IDX_W-1:0];

    assign cmda_o.wr_idx   = wr_idx_q;
    assign cmda_o.wr_data  = wr_data_q;
    assign cmda_o.wr_en    = ld_cmda_q;
    assign cmda_o.commit   = commit_q;
    assign cmda_o.rd_idx   = mon_addr_i[`BANK_IDX_W-1:0];

    assign ps_target_o = $signed(wr_data_q);

    // a load reaches one place only among banks and shifter
    a_one_target: assert property (@(posedge rst_in) disable iff (rst_sync)
        $onehot0({lane0_o.wr_en, lane1_o.wr_en, cmda_o.wr_en, ps_we_o}));

endmodule

// ==== dly_wr_if.sv ====
// delay bank access bus: decoded loads, shared set strobe and active value readback
`timescale 1ns/1ps
`include "phy_consts.svh"

interface dly_wr_if;
    import phy_pkg::*;

    logic [`BANK_IDX_W-1:0] wr_idx;     // pending entry to load
    dly_val_t               wr_data;    // value for that entry
    logic                   wr_en;      // one-cycle load strobe
    logic                   commit;     // one-cycle set, all banks at once
    logic [`BANK_IDX_W-1:0] rd_idx;     // readback entry
    dly_val_t               rd_data;    // active value, combinational from rd_idx

    modport ctrl (
        output wr_idx, wr_data, wr_en, commit, rd_idx,
        input  rd_data
    );

    modport bank (
        input  wr_idx, wr_data, wr_en, commit, rd_idx,
        output rd_data
    );

endinterface

// ==== phase_shift_ctrl.sv ====
// clock phase shifter: steps the phase one unit at a time toward a clamped signed target
`timescale 1ns/1ps
`include "phy_consts.svh"

module phase_shift_ctrl (
    input  logic            rst_in,         // clock
    input  logic            rst_i,          // synced reset
    input  logic            ps_we_i,        // registered phase write
    input  phy_pkg::phase_t ps_target_i,
    output logic            ps_rdy_o,
    output phy_pkg::phase_t ps_out_o        // current phase
);
    import phy_pkg::*;

    localparam int               TMR_W    = $clog2(`PS_STEP_CYCLES);
    localparam phase_t           PS_MAX   = phase_t'(`PS_LIMIT);
    localparam phase_t           PS_MIN   = -PS_MAX;
    localparam logic [TMR_W-1:0] TMR_LOAD = TMR_W'(`PS_STEP_CYCLES - 2); // wait + step = period

    ps_state_e          ps_state;
    logic [TMR_W-1:0]   step_tmr;
    phase_t             tgt_q;              // latched clamped target
    phase_t             tgt_clamp;
    phase_t             out_nxt;            // phase after one step
    logic               ps_start;

    always_comb begin
        if (ps_target_i < PS_MIN) begin
            tgt_clamp = PS_MIN;             // -128 has no mirror
        end else if (ps_target_i > PS_MAX) begin
            tgt_clamp = PS_MAX;
        end else begin
            tgt_clamp = ps_target_i;
        end
    end

    assign ps_start = ps_we_i && ps_rdy_o && (tgt_clamp != ps_out_o); // busy writes dropped
    assign out_nxt  = (ps_out_o < tgt_q) ? ps_out_o + phase_t'(1) : ps_out_o - phase_t'(1);

    always_ff @(posedge rst_in or posedge rst_i) begin
        if (rst_i) begin
            ps_state <= PS_IDLE;
            step_tmr <= '0;
            tgt_q    <= '0;
            ps_out_o <= '0;
            ps_rdy_o <= 1'b1;
        end else begin
            case (ps_state)
                PS_IDLE: begin
                    if (ps_start) begin
                        ps_state <= PS_WAIT;
                        step_tmr <= TMR_LOAD;
                        tgt_q    <= tgt_clamp;
                        ps_rdy_o <= 1'b0;
                    end else begin
                        ps_rdy_o <= 1'b1;   // one cycle late after last step
                    end
                end
                PS_WAIT: begin
                    if (step_tmr == '0) begin
                        ps_state <= PS_STEP;
                    end else begin
                        step_tmr <= step_tmr - 1'b1;
                    end
                end
                PS_STEP: begin
                    ps_out_o <= out_nxt;
                    step_tmr <= TMR_LOAD;
                    ps_state <= (out_nxt == tgt_q) ? PS_IDLE : PS_WAIT;
                end
                default: ps_state <= PS_IDLE;
            endcase
        end
    end

    // phase never leaves the symmetric range
    a_ps_range: assert property (@(posedge rst_in) disable iff (rst_i)
        (ps_out_o >= PS_MIN) && (ps_out_o <= PS_MAX));

    // ready only while parked
    a_rdy_idle: assert property (@(posedge rst_in) disable iff (rst_i)
        ps_rdy_o |-> (ps_state == PS_IDLE));

endmodule

// ==== phy_consts.svh ====
// ddr3 phy control constants: config address fields, bank sizes, phase shifter limits
`ifndef PHY_CONSTS_SVH
`define PHY_CONSTS_SVH

// config write port
`define DLY_ADDR_W      7       // delay/phase address width
`define DLY_DATA_W      8       // one delay value

// address fields
`define BANK_SEL_MSB    6       // target field, top bits
`define BANK_SEL_LSB    5
`define BANK_IDX_W      5       // entry index inside a bank

// bank sizes
`define LANE_DLY_NUM    10      // 8 dq + dqs + dm
`define CMDA_DLY_NUM    24      // address, bank, control pins

// clock phase shifter
`define PS_ADDR         7'h60   // phase target register
`define PS_LIMIT        127     // max |phase|
`define PS_STEP_CYCLES  4       // clocks per phase unit

`endif

// ==== phy_ctrl_top.sv ====
// ddr3 phy control top with config decode, lane and cmd/addr delay banks and clock phase shifter
`timescale 1ns/1ps
`include "phy_consts.svh"

module phy_ctrl_top (
    input  logic                   rst_in,      // clock
    input  logic                   clk_div,     // async active-high reset
    input  logic [`DLY_ADDR_W-1:0] dly_addr_i,  // bank select + entry
    input  phy_pkg::dly_val_t      dly_data_i,
    input  logic                   ld_delay_i,  // load one pending value
    input  logic                   set_i,       // apply all pending values
    input  logic [`DLY_ADDR_W-1:0] mon_addr_i,  // readback address
    output phy_pkg::dly_val_t      mon_data_o,
    output logic                   ps_rdy_o,
    output phy_pkg::phase_t        ps_out_o
);
    import phy_pkg::*;

    logic            rst_sync;              // internal reset for all blocks
    logic            ps_we;
    phase_t          ps_target;

    dly_wr_if lane0_if ();
    dly_wr_if lane1_if ();
    dly_wr_if cmda_if ();

    dly_cfg_ctrl dly_cfg_ctrl_i (
        .rst_in      (rst_in),
        .clk_div     (clk_div),
        .dly_addr_i  (dly_addr_i),
        .dly_data_i  (dly_data_i),
        .ld_delay_i  (ld_delay_i),
        .set_i       (set_i),
        .mon_addr_i  (mon_addr_i),
        .lane0_o     (lane0_if.ctrl),
        .lane1_o     (lane1_if.ctrl),
        .cmda_o      (cmda_if.ctrl),
        .ps_we_o     (ps_we),
        .ps_target_o (ps_target),
        .mon_data_o  (mon_data_o),
        .rst_sync_o  (rst_sync)
    );

    delay_bank #(.NUM_ENTRIES(`LANE_DLY_NUM)) lane0_bank_i (
        .rst_in (rst_in),
        .rst_i  (rst_sync),
        .wr_bus (lane0_if.bank)             // dq[7:0], dqs, dm
    );

    delay_bank #(.NUM_ENTRIES(`LANE_DLY_NUM)) lane1_bank_i (
        .rst_in (rst_in),
        .rst_i  (rst_sync),
        .wr_bus (lane1_if.bank)             // dq[15:8], dqs, dm
    );

    delay_bank #(.NUM_ENTRIES(`CMDA_DLY_NUM)) cmda_bank_i (
        .rst_in (rst_in),
        .rst_i  (rst_sync),
        .wr_bus (cmda_if.bank)
    );

    phase_shift_ctrl phase_shift_ctrl_i (
        .rst_in      (rst_in),
        .rst_i       (rst_sync),
        .ps_we_i     (ps_we),
        .ps_target_i (ps_target),
        .ps_rdy_o    (ps_rdy_o),
        .ps_out_o    (ps_out_o)
    );

endmodule

// ==== phy_pkg.sv ====
// ddr3 phy control types: write targets, phase shifter states, delay and phase values
`include "phy_consts.svh"

package phy_pkg;

    // where a config write lands
    typedef enum logic [2:0] {
        TGT_LANE0,              // data byte lane 0
        TGT_LANE1,              // data byte lane 1
        TGT_CMDA,               // command/address pins
        TGT_PHASE,              // clock phase shifter
        TGT_NONE                // unmapped, dropped
    } dly_target_e;

    // phase shifter sequencing
    typedef enum logic [1:0] {
        PS_IDLE,                // ready, waiting for target
        PS_WAIT,                // step timer running
        PS_STEP                 // move phase by one unit
    } ps_state_e;

    typedef logic [`DLY_DATA_W-1:0]        dly_val_t;   // raw tap count
    typedef logic signed [`DLY_DATA_W-1:0] phase_t;     // signed phase units

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator and run; exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module tb_phy_ctrl -o tb_phy_ctrl &&
./obj_dir/tb_phy_ctrl || exit 1

// ==== src.f ====
+incdir+.
phy_pkg.sv
dly_wr_if.sv
dly_cfg_ctrl.sv
delay_bank.sv
phase_shift_ctrl.sv
phy_ctrl_top.sv
tb_phy_ctrl.sv

// ==== tb_phy_ctrl.sv ====
// ddr3 phy control testbench: random delay loads, set commits, readback and phase stepping
`timescale 1ns/1ps
`include "phy_consts.svh"

module tb_phy_ctrl;
    import phy_pkg::*;

    typedef logic [`DLY_ADDR_W-1:0] addr_t;

    localparam int CLK_HALF = 50;                   // 100 ns period
    localparam int N_LOADS  = 48;                   // random loads per round
    localparam int N_PHASE  = 10;                   // random phase targets
    localparam int PS_WORST = 2 * `PS_LIMIT * `PS_STEP_CYCLES + 16; // full swing
    localparam int WDOG_CYC = 2 * (16 + 5 * 256 + 4 * N_LOADS + 64 + (N_PHASE + 3) * PS_WORST);

    logic     rst_in;                               // clock
    logic     clk_div;                              // async reset, active high
    addr_t    dly_addr_i;
    dly_val_t dly_data_i;
    logic     ld_delay_i;
    logic     set_i;
    addr_t    mon_addr_i;
    dly_val_t mon_data_o;
    logic     ps_rdy_o;
    phase_t   ps_out_o;

    int unsigned rng_state = 99999;                 // lcg seed
    int          fail_cnt  = 0;
    dly_val_t    pend_m   [3][32] = '{default: '0}; // model pending, lane0/lane1/cmda
    dly_val_t    active_m [3][32] = '{default: '0}; // model active

    phy_ctrl_top dut_i (.*);

    initial rst_in = 1'b0;
    always #(CLK_HALF) rst_in = ~rst_in;

    initial begin
        #(WDOG_CYC * 2 * CLK_HALF);
        $display("ERROR: watchdog expired, the DUT stopped responding");
        $display("Test failures found");
        $fatal(1, "watchdog");
    end

    function automatic int unsigned rand_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 8;                      // low bits cycle too fast
    endfunction

    function automatic int bank_size(input int bank);
        return (bank == 2) ? `CMDA_DLY_NUM : `LANE_DLY_NUM;
    endfunction

    // expected readback, straight from the address map
    function automatic int model_read(input addr_t addr);
        int bank;
        int idx;
        bank = int'(addr[`BANK_SEL_MSB:`BANK_SEL_LSB]);
        idx  = int'(addr[`BANK_IDX_W-1:0]);
        if (bank > 2 || idx >= bank_size(bank)) begin
            return 0;                               // phase reg, holes, past bank end
        end
        return int'(active_m[bank][idx]);
    endfunction

    function automatic int clamp_phase(input dly_val_t raw);
        int p;
        p = int'(phase_t'(raw));
        return (p < -`PS_LIMIT) ? -`PS_LIMIT : p;   // -128 folds to -127
    endfunction

    task automatic check_value(input string test, input int expected, input int actual);
        assert (expected == actual) else begin
            fail_cnt++;
            $display("MISMATCH %s: expected %0d, actual %0d", test, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        assert (ok) else begin
            fail_cnt++;
            $display("ERROR: %s", what);
            $display("Test failures found");
            $fatal(1, "stopped at first error");
        end
    endtask

    // one cycle on the config port, model follows load/set order
    task automatic drive_cycle(input logic ld, input addr_t addr, input dly_val_t data,
                               input logic do_set);
        int bank;
        int idx;
        bank = int'(addr[`BANK_SEL_MSB:`BANK_SEL_LSB]);
        idx  = int'(addr[`BANK_IDX_W-1:0]);
        @(posedge rst_in);
        dly_addr_i <= addr;
        dly_data_i <= data;
        ld_delay_i <= ld;
        set_i      <= do_set;
        @(posedge rst_in);
        ld_delay_i <= 1'b0;
        set_i      <= 1'b0;
        if (do_set) begin
            active_m = pend_m;                      // set sees pending before this load
        end
        if (ld && bank < 3 && idx < bank_size(bank)) begin
            pend_m[bank][idx] = data;
        end
    endtask

    task automatic read_expect(input string test, input addr_t addr, input int expected);
        @(posedge rst_in);
        mon_addr_i <= addr;
        @(posedge rst_in);
        @(negedge rst_in);                          // registered readback settled
        check_value($sformatf("%s @%02h", test, addr), expected, int'(mon_data_o));
    endtask

    task automatic scan_all(input string test);
        for (int a = 0; a < 2 ** `DLY_ADDR_W; a++) begin
            read_expect(test, addr_t'(a), model_read(addr_t'(a)));
        end
    endtask

    // write a phase target and follow the shifter until ready again
    task automatic phase_move(input string test, input dly_val_t raw, input logic busy_write);
        int start;
        int target;
        int prev;
        int waited;
        start  = int'(ps_out_o);
        target = clamp_phase(raw);
        waited = 0;
        check_cond(ps_rdy_o, "phase shifter busy before a new target");
        drive_cycle(1'b1, `PS_ADDR, raw, 1'b0);
        @(posedge rst_in);
        @(negedge rst_in);                          // strobe reached the shifter
        check_value({test, " rdy"}, (target == start) ? 1 : 0, int'(ps_rdy_o));
        if (busy_write) begin
            drive_cycle(1'b1, `PS_ADDR, ~raw, 1'b0); // must be dropped
            @(negedge rst_in);
        end
        prev = start;
        while (ps_rdy_o !== 1'b1) begin
            @(negedge rst_in);
            check_cond((int'(ps_out_o) - prev) inside {-1, 0, 1},
                       "phase moved by more than one unit between samples");
            prev = int'(ps_out_o);
            waited++;
            check_cond(waited < PS_WORST, "phase shifter never returned to ready");
        end
        check_value({test, " phase"}, target, int'(ps_out_o));
    endtask

    initial begin
        addr_t    a;
        dly_val_t v_old;
        dly_val_t v_new;
        int       t;
        clk_div    = 1'b1;
        dly_addr_i = '0;
        dly_data_i = '0;
        ld_delay_i = 1'b0;
        set_i      = 1'b0;
        mon_addr_i = '0;
        repeat (8) @(posedge rst_in);
        clk_div <= 1'b0;
        repeat (4) @(posedge rst_in);               // sync chain lets go on falling edges
        @(negedge rst_in);

        check_value("reset rdy", 1, int'(ps_rdy_o));
        check_value("reset phase", 0, int'(ps_out_o));
        scan_all("reset readback");

        for (int r = 0; r < 2; r++) begin
            for (int n = 0; n < N_LOADS; n++) begin
                t = int'(rand_next() % 4);
                a = (t == 3) ? addr_t'(`PS_ADDR + 1 + rand_next() % 31)     // unmapped hole
                             : addr_t'((t << `BANK_SEL_LSB) | (rand_next() % 32));
                drive_cycle(1'b1, a, dly_val_t'(rand_next()), 1'b0);
            end
            scan_all("loads without set");
            drive_cycle(1'b0, '0, '0, 1'b1);
            scan_all("after set");
        end

        // load and set in the same cycle commit the older pending value
        for (int k = 0; k < 4; k++) begin
            t     = int'(rand_next() % 3);
            a     = addr_t'((t << `BANK_SEL_LSB) | (rand_next() % bank_size(t)));
            v_old = dly_val_t'(rand_next());
            v_new = v_old ^ dly_val_t'(1 + rand_next() % 255);
            drive_cycle(1'b1, a, v_old, 1'b0);
            drive_cycle(1'b1, a, v_new, 1'b1);
            read_expect("load with set", a, int'(v_old));
            drive_cycle(1'b0, '0, '0, 1'b1);
            read_expect("set after load with set", a, int'(v_new));
        end

        phase_move("phase -128", 8'h80, 1'b0);
        phase_move("phase equal", 8'h81, 1'b0);    // already at -127
        for (int n = 0; n < N_PHASE; n++) begin
            phase_move("phase random", dly_val_t'(rand_next()), 1'b0);
        end
        t = int'(ps_out_o);
        t = (t >= 0) ? t - 40 : t + 40;             // far enough to stay busy
        phase_move("phase busy write", dly_val_t'(t), 1'b1);

        if (fail_cnt == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "checks failed");
        end
    end

endmodule
